// ==== io_types_pkg.sv ====
package io_types_pkg;

  // Bus word and address widths
  localparam int DATA_W = 16;
  localparam int ADDR_W = 16;

  typedef logic [DATA_W-1:0] io_data_t;  // Bus data word
  typedef logic [ADDR_W-1:0] io_addr_t;  // Bus address

  // One transfer from the bus master
  // wr is a single-cycle write strobe; reads follow addr with no strobe
  typedef struct packed {
    logic     wr;     // Write strobe, one cycle
    io_addr_t addr;   // Register address incl. page and mode bits
    io_data_t wdata;  // Write data
  } io_bus_t;

  // Sigma-delta duty level
  // Pulse density is level / 65536
  typedef logic [15:0] sdm_level_t;

  // LED colour vector
  // Bit 0 blue, bit 1 red, bit 2 green
  typedef logic [2:0] rgb_t;

  localparam int RGB_BLUE  = 0;
  localparam int RGB_RED   = 1;
  localparam int RGB_GREEN = 2;

endpackage

// ==== io_map_pkg.sv ====
package io_map_pkg;

  // Write modes, taken from addr[1:0]
  typedef enum logic [1:0] {
    mode_write  = 2'd0,  // Plain write
    mode_clear  = 2'd1,  // Clear bits set in wdata
    mode_set    = 2'd2,  // Set bits set in wdata
    mode_toggle = 2'd3   // Invert bits set in wdata
  } wr_mode_t;

  // Page-select address bits, one hot per page
  // More than one page may be selected on a read; results are ORed
  localparam int GPIO_IN_BIT  = 8;   // Port input sample, read only
  localparam int GPIO_OUT_BIT = 9;   // Port output register
  localparam int GPIO_DIR_BIT = 10;  // Port direction, 1 = output
  localparam int MISC_BIT     = 11;  // LED and modulator registers
  localparam int TICKS_BIT    = 14;  // Tick counter, writable
  localparam int CYCLES_BIT   = 15;  // Free-running cycle counter

  // Selector codes in addr[8:4] under the misc page
  localparam logic [4:0] SEL_LED       = 5'd11;
  localparam logic [4:0] SEL_SDM_RED   = 5'd12;
  localparam logic [4:0] SEL_SDM_GREEN = 5'd13;
  localparam logic [4:0] SEL_SDM_BLUE  = 5'd14;

  // Single-cycle write strobes to the register blocks
  typedef struct packed {
    logic gpio_out;
    logic gpio_dir;
    logic led;
    logic sdm_red;
    logic sdm_green;
    logic sdm_blue;
    logic ticks;
  } io_strobe_t;

endpackage

// ==== bit_op_reg.sv ====
module bit_op_reg #(
  parameter int WIDTH = 16
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 wr,     // Write strobe
  input  io_map_pkg::wr_mode_t mode,   // Update op
  input  logic [WIDTH-1:0]     wdata,  // Value or bit mask
  output logic [WIDTH-1:0]     q
);
  import io_map_pkg::*;

  logic [WIDTH-1:0] q_next;

  // In the bit modes wdata is a mask; ones select the bits to change
  always_comb begin
    unique case (mode)
      mode_write:  q_next = wdata;
      mode_clear:  q_next = q & ~wdata;
      mode_set:    q_next = q | wdata;
      mode_toggle: q_next = q ^ wdata;
      default:     q_next = q;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      q <= '0;
    end else if (wr) begin
      q <= q_next;  // New value visible next cycle
    end
  end

endmodule

// ==== io_decode.sv ====
module io_decode #(
  parameter int GPIO_WIDTH = 8
) (
  input  io_types_pkg::io_bus_t    bus,
  output io_map_pkg::io_strobe_t   strobe,
  output io_map_pkg::wr_mode_t     mode,
  output io_types_pkg::io_data_t   wdata,
  input  logic [GPIO_WIDTH-1:0]    gpio_in_val,
  input  logic [GPIO_WIDTH-1:0]    gpio_out_val,
  input  logic [GPIO_WIDTH-1:0]    gpio_dir_val,
  input  io_types_pkg::rgb_t       led_val,
  input  io_types_pkg::sdm_level_t sdm_red_val,
  input  io_types_pkg::sdm_level_t sdm_green_val,
  input  io_types_pkg::sdm_level_t sdm_blue_val,
  input  io_types_pkg::io_data_t   ticks_val,
  input  io_types_pkg::io_data_t   cycles_val,
  output io_types_pkg::io_data_t   rdata
);
  import io_types_pkg::*;
  import io_map_pkg::*;

  logic       misc_page;  // Misc page bit
  logic [4:0] sel;        // Selector field
  logic       sel_led;
  logic       sel_red;
  logic       sel_green;
  logic       sel_blue;

  assign misc_page = bus.addr[MISC_BIT];
  assign sel       = bus.addr[8:4];

  // Misc registers need page bit and matching selector
  assign sel_led   = misc_page & (sel == SEL_LED);
  assign sel_red   = misc_page & (sel == SEL_SDM_RED);
  assign sel_green = misc_page & (sel == SEL_SDM_GREEN);
  assign sel_blue  = misc_page & (sel == SEL_SDM_BLUE);

  assign mode  = wr_mode_t'(bus.addr[1:0]);  // Low address bits pick the op
  assign wdata = bus.wdata;

  // Write strobes, all qualified by the bus strobe
  always_comb begin
    strobe           = '0;
    strobe.gpio_out  = bus.wr & bus.addr[GPIO_OUT_BIT];
    strobe.gpio_dir  = bus.wr & bus.addr[GPIO_DIR_BIT];
    strobe.led       = bus.wr & sel_led;
    strobe.sdm_red   = bus.wr & sel_red;
    strobe.sdm_green = bus.wr & sel_green;
    strobe.sdm_blue  = bus.wr & sel_blue;
    strobe.ticks     = bus.wr & bus.addr[TICKS_BIT];
  end

  // Read mux, purely combinational from addr
  // Every selected page contributes; narrow values are zero-extended
  always_comb begin
    rdata = '0;
    if (bus.addr[GPIO_IN_BIT]) begin
      rdata |= io_data_t'(gpio_in_val);
    end
    if (bus.addr[GPIO_OUT_BIT]) begin
      rdata |= io_data_t'(gpio_out_val);
    end
    if (bus.addr[GPIO_DIR_BIT]) begin
      rdata |= io_data_t'(gpio_dir_val);
    end
    if (sel_led) rdata |= io_data_t'(led_val);  // Enable bits only
    if (sel_red) rdata |= io_data_t'(sdm_red_val);
    if (sel_green) rdata |= io_data_t'(sdm_green_val);
    if (sel_blue) rdata |= io_data_t'(sdm_blue_val);
    if (bus.addr[TICKS_BIT]) begin
      rdata |= ticks_val;
    end
    if (bus.addr[CYCLES_BIT]) begin
      rdata |= cycles_val;
    end
  end

endmodule

// ==== gpio_port.sv ====
module gpio_port #(
  parameter int GPIO_WIDTH = 8
) (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   out_wr,  // Output register strobe
  input  logic                   dir_wr,  // Direction register strobe
  input  io_map_pkg::wr_mode_t   mode,
  input  io_types_pkg::io_data_t wdata,
  input  logic [GPIO_WIDTH-1:0]  pin_in,  // Asynchronous pin levels
  output logic [GPIO_WIDTH-1:0]  pin_out,
  output logic [GPIO_WIDTH-1:0]  pin_oe,  // 1 = drive, 0 = input
  output logic [GPIO_WIDTH-1:0]  in_val   // Synchronized input sample
);

  logic [GPIO_WIDTH-1:0] in_meta;  // First sync stage
  logic [GPIO_WIDTH-1:0] in_sync;  // Second sync stage

  // Output register, drives the pins directly
  bit_op_reg #(
    .WIDTH (GPIO_WIDTH)
  ) i_out_reg (
    .clk    (clk),
    .arst_n (arst_n),
    .wr     (out_wr),
    .mode   (mode),
    .wdata  (wdata[GPIO_WIDTH-1:0]),
    .q      (pin_out)
  );

  // Direction register
  // Cleared by reset, so every pin starts as an input
  bit_op_reg #(
    .WIDTH (GPIO_WIDTH)
  ) i_dir_reg (
    .clk    (clk),
    .arst_n (arst_n),
    .wr     (dir_wr),
    .mode   (mode),
    .wdata  (wdata[GPIO_WIDTH-1:0]),
    .q      (pin_oe)
  );

  // Two-flop synchronizer
  // A pin change shows up on in_val after two edges
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      in_meta <= '0;
      in_sync <= '0;
    end else begin
      in_meta <= pin_in;   // May go metastable
      in_sync <= in_meta;  // Settled
    end
  end

  assign in_val = in_sync;

endmodule

// ==== led_sdm.sv ====
module led_sdm (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     led_wr,    // Enable register strobe
  input  logic                     red_wr,    // Level strobes
  input  logic                     green_wr,
  input  logic                     blue_wr,
  input  io_map_pkg::wr_mode_t     mode,
  input  io_types_pkg::io_data_t   wdata,
  output io_types_pkg::rgb_t       led_val,   // Static enables
  output io_types_pkg::sdm_level_t red_val,
  output io_types_pkg::sdm_level_t green_val,
  output io_types_pkg::sdm_level_t blue_val,
  output io_types_pkg::rgb_t       rgb_pwm    // Colour drive
);
  import io_types_pkg::*;

  rgb_t chan_wr;  // Level strobes, indexed by colour bit
  rgb_t pulse;    // Registered modulator outputs

  assign chan_wr[RGB_BLUE]  = blue_wr;
  assign chan_wr[RGB_RED]   = red_wr;
  assign chan_wr[RGB_GREEN] = green_wr;

  // Static enables support the bit modes like the port registers
  bit_op_reg #(
    .WIDTH ($bits(rgb_t))
  ) i_led_reg (
    .clk    (clk),
    .arst_n (arst_n),
    .wr     (led_wr),
    .mode   (mode),
    .wdata  (wdata[$bits(rgb_t)-1:0]),
    .q      (led_val)
  );

  // First-order sigma-delta, one per colour
  // Carry out of phase + level is the pulse; density is level / 65536
  for (genvar i = 0; i < $bits(rgb_t); i++) begin : g_chan
    sdm_level_t level;  // Duty level, plain write only
    sdm_level_t phase;  // Accumulator
    logic       carry;

    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        level <= '0;
        phase <= '0;
        carry <= 1'b0;
      end else begin
        if (chan_wr[i]) level <= wdata;
        {carry, phase} <= phase + level;  // 17-bit sum keeps the carry
      end
    end

    assign pulse[i] = carry;
  end

  assign red_val   = g_chan[RGB_RED].level;
  assign green_val = g_chan[RGB_GREEN].level;
  assign blue_val  = g_chan[RGB_BLUE].level;

  assign rgb_pwm = led_val | pulse;  // Enable forces the colour on

endmodule

// ==== tick_timer.sv ====
module tick_timer (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   ticks_wr,    // Load strobe
  input  io_types_pkg::io_data_t wdata,
  output io_types_pkg::io_data_t ticks_val,
  output io_types_pkg::io_data_t cycles_val,
  output logic                   irq          // One cycle on tick wrap
);
  import io_types_pkg::*;

  localparam int DW = $bits(io_data_t);

  logic [DW:0] ticks_inc;  // Count plus one, with carry

  assign ticks_inc = {1'b0, ticks_val} + 1'b1;

  // Tick counter, a write takes priority over counting
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ticks_val <= '0;
    end else if (ticks_wr) begin
      ticks_val <= wdata;
    end else begin
      ticks_val <= ticks_inc[DW-1:0];
    end
  end

  // Interrupt rises on the same edge the counter wraps to zero
  // After loading V that is 65536 - V edges later
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      irq <= 1'b0;
    end else begin
      irq <= ~ticks_wr & ticks_inc[DW];  // No wrap on a load edge
    end
  end

  // Free-running cycle counter
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cycles_val <= '0;
    end else begin
      cycles_val <= cycles_val + 1'b1;  // Wraps mod 65536
    end
  end

endmodule

// ==== io_top.sv ====
module io_top #(
  parameter int GPIO_WIDTH = 8  // Port width, 1 to 16
) (
  input  logic                   clk,
  input  logic                   arst_n,
  input  io_types_pkg::io_bus_t  bus,       // From the bus master
  output io_types_pkg::io_data_t io_rdata,  // Combinational read data
  input  logic [GPIO_WIDTH-1:0]  gpio_in,
  output logic [GPIO_WIDTH-1:0]  gpio_out,
  output logic [GPIO_WIDTH-1:0]  gpio_oe,
  output io_types_pkg::rgb_t     rgb_pwm,
  output logic                   irq
);
  import io_types_pkg::*;
  import io_map_pkg::*;

  io_strobe_t            strobe;
  wr_mode_t              mode;
  io_data_t              wdata;
  logic [GPIO_WIDTH-1:0] gpio_in_val;  // Synchronized pins
  rgb_t                  led_val;
  sdm_level_t            sdm_red_val;
  sdm_level_t            sdm_green_val;
  sdm_level_t            sdm_blue_val;
  io_data_t              ticks_val;
  io_data_t              cycles_val;

  io_decode #(
    .GPIO_WIDTH (GPIO_WIDTH)
  ) i_decode (
    .bus           (bus),
    .strobe        (strobe),
    .mode          (mode),
    .wdata         (wdata),
    .gpio_in_val   (gpio_in_val),
    .gpio_out_val  (gpio_out),  // Pins double as readback
    .gpio_dir_val  (gpio_oe),
    .led_val       (led_val),
    .sdm_red_val   (sdm_red_val),
    .sdm_green_val (sdm_green_val),
    .sdm_blue_val  (sdm_blue_val),
    .ticks_val     (ticks_val),
    .cycles_val    (cycles_val),
    .rdata         (io_rdata)
  );

  gpio_port #(
    .GPIO_WIDTH (GPIO_WIDTH)
  ) i_gpio (
    .clk     (clk),
    .arst_n  (arst_n),
    .out_wr  (strobe.gpio_out),
    .dir_wr  (strobe.gpio_dir),
    .mode    (mode),
    .wdata   (wdata),
    .pin_in  (gpio_in),
    .pin_out (gpio_out),
    .pin_oe  (gpio_oe),
    .in_val  (gpio_in_val)
  );

  led_sdm i_led (
    .clk       (clk),
    .arst_n    (arst_n),
    .led_wr    (strobe.led),
    .red_wr    (strobe.sdm_red),
    .green_wr  (strobe.sdm_green),
    .blue_wr   (strobe.sdm_blue),
    .mode      (mode),
    .wdata     (wdata),
    .led_val   (led_val),
    .red_val   (sdm_red_val),
    .green_val (sdm_green_val),
    .blue_val  (sdm_blue_val),
    .rgb_pwm   (rgb_pwm)
  );

  tick_timer i_timer (
    .clk        (clk),
    .arst_n     (arst_n),
    .ticks_wr   (strobe.ticks),
    .wdata      (wdata),
    .ticks_val  (ticks_val),
    .cycles_val (cycles_val),
    .irq        (irq)
  );

endmodule

// ==== tb_io_top.sv ====
module tb_io_top;
  import io_types_pkg::*;

  localparam int GPIO_WIDTH = 8;
  localparam int HALF       = 50;   // Half clock period
  localparam int IRQ_LIMIT  = 200;  // Cycles to wait for irq

  // Register addresses with the write mode in bits 1:0
  localparam logic [15:0] A_GPIO_IN   = 16'h0100;
  localparam logic [15:0] A_GPIO_OUT  = 16'h0200;
  localparam logic [15:0] A_GPIO_DIR  = 16'h0400;
  localparam logic [15:0] A_LED       = 16'h08B0;  // Misc page with selector 11
  localparam logic [15:0] A_SDM_RED   = 16'h08C0;  // Selector 12
  localparam logic [15:0] A_SDM_GREEN = 16'h08D0;
  localparam logic [15:0] A_SDM_BLUE  = 16'h08E0;
  localparam logic [15:0] A_TICKS     = 16'h4000;
  localparam logic [15:0] A_CYCLES    = 16'h8000;

  localparam logic [15:0] TICK_LOAD = 16'hFFF0;

  logic                  clk;
  logic                  arst_n;
  io_bus_t               bus;
  io_data_t              io_rdata;
  logic [GPIO_WIDTH-1:0] gpio_in;
  logic [GPIO_WIDTH-1:0] gpio_out;
  logic [GPIO_WIDTH-1:0] gpio_oe;
  rgb_t                  rgb_pwm;
  logic                  irq;

  logic [15:0] lfsr;           // Random source state
  int          err_count;      // Value mismatches
  int          timeout_count;  // Waits that ran out
  int          check_count;

  io_top #(
    .GPIO_WIDTH (GPIO_WIDTH)
  ) i_dut (
    .clk      (clk),
    .arst_n   (arst_n),
    .bus      (bus),
    .io_rdata (io_rdata),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out),
    .gpio_oe  (gpio_oe),
    .rgb_pwm  (rgb_pwm),
    .irq      (irq)
  );

  initial begin
    clk = 1'b0;
    forever #HALF clk = ~clk;
  end

  // Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) n = n ^ 16'hB400;
    return n;
  endfunction

  // One LFSR step per bit taken
  task automatic rand_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[14:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // Expected register value after a write in the given mode
  function automatic logic [15:0] apply_op(input logic [15:0] cur, input logic [1:0] op,
                                           input logic [15:0] mask);
    case (op)
      2'd0:    return mask;         // Plain write
      2'd1:    return cur & ~mask;  // Clear
      2'd2:    return cur | mask;   // Set
      default: return cur ^ mask;   // Toggle
    endcase
  endfunction

  task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
    check_count++;
    if (got !== exp) begin
      $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
      err_count++;
    end
  endtask

  // Write strobe high across exactly one rising edge
  task automatic bus_write(input logic [15:0] addr, input logic [15:0] data);
    @(negedge clk);
    bus.wr    = 1'b1;
    bus.addr  = addr;
    bus.wdata = data;
    @(negedge clk);
    bus.wr = 1'b0;  // Write edge has passed
  endtask

  task automatic bus_read(input logic [15:0] addr, output logic [15:0] data);
    @(negedge clk);
    bus.addr = addr;
    #(HALF / 2);      // Settles well before the next rising edge
    data = io_rdata;
  endtask

  // Count high samples per colour over n cycles
  task automatic count_pulses(input int n, output int r, output int g, output int b);
    r = 0;
    g = 0;
    b = 0;
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      if (rgb_pwm[1]) r++;  // Red
      if (rgb_pwm[2]) g++;  // Green
      if (rgb_pwm[0]) b++;  // Blue
    end
  endtask

  task automatic reset_values();
    logic [15:0] v;
    bus_read(A_GPIO_OUT, v);
    check("gpio_out reg", v, 16'h0);
    bus_read(A_GPIO_DIR, v);
    check("gpio_dir reg", v, 16'h0);
    bus_read(A_LED, v);
    check("led reg", v, 16'h0);
    bus_read(A_SDM_RED, v);
    check("sdm_red level", v, 16'h0);
    bus_read(A_SDM_GREEN, v);
    check("sdm_green level", v, 16'h0);
    bus_read(A_SDM_BLUE, v);
    check("sdm_blue level", v, 16'h0);
    check("gpio_oe", 16'(gpio_oe), 16'h0);  // All pins inputs
    check("irq", 16'(irq), 16'h0);
  endtask

  task automatic bit_op_modes();
    logic [15:0] out_m;
    logic [15:0] dir_m;
    logic [15:0] led_m;
    logic [15:0] d;
    logic [15:0] m;
    logic [15:0] v;
    out_m = '0;
    dir_m = '0;
    led_m = '0;
    for (int i = 0; i < 24; i++) begin
      m = 16'((i / 2) % 4);  // Cycle through all four modes
      rand_bits(8, d);
      if (i % 2 == 0) begin
        bus_write(A_GPIO_OUT | m, d);
        out_m = apply_op(out_m, m[1:0], d);
        bus_read(A_GPIO_OUT, v);
        check("gpio_out reg", v, out_m);
        check("gpio_out", 16'(gpio_out), out_m);
      end else begin
        bus_write(A_GPIO_DIR | m, d);
        dir_m = apply_op(dir_m, m[1:0], d);
        bus_read(A_GPIO_DIR, v);
        check("gpio_dir reg", v, dir_m);
        check("gpio_oe", 16'(gpio_oe), dir_m);
      end
    end
    // With levels at 0 rgb_pwm shows only the enables
    for (int i = 0; i < 12; i++) begin
      m = 16'(i % 4);
      rand_bits(3, d);
      bus_write(A_LED | m, d);
      led_m = apply_op(led_m, m[1:0], d);
      bus_read(A_LED, v);
      check("led reg", v, led_m);
      check("rgb_pwm", 16'(rgb_pwm), led_m);
    end
  endtask

  task automatic port_inputs();
    logic [15:0] d;
    logic [15:0] v;
    for (int i = 0; i < 6; i++) begin
      rand_bits(8, d);
      @(negedge clk);
      gpio_in = d[GPIO_WIDTH-1:0];
      repeat (2) @(posedge clk);  // Through the synchronizer
      bus_read(A_GPIO_IN, v);
      check("gpio_in page", v, d);
    end
  endtask

  task automatic sdm_density();
    logic [15:0] v;
    int          r;
    int          g;
    int          b;
    bus_write(A_LED, 16'h0);  // Enables off
    bus_write(A_SDM_RED, 16'h4000);
    bus_write(A_SDM_GREEN, 16'h4000);
    bus_write(A_SDM_BLUE, 16'h4000);
    bus_read(A_SDM_RED, v);
    check("sdm_red level", v, 16'h4000);
    bus_read(A_SDM_GREEN, v);
    check("sdm_green level", v, 16'h4000);
    bus_read(A_SDM_BLUE, v);
    check("sdm_blue level", v, 16'h4000);
    count_pulses(64, r, g, b);  // Quarter density
    check("red pulses", 16'(r), 16'd16);
    check("green pulses", 16'(g), 16'd16);
    check("blue pulses", 16'(b), 16'd16);
    bus_write(A_LED, 16'h0007);
    count_pulses(64, r, g, b);  // Enable forces high
    check("red high", 16'(r), 16'd64);
    check("green high", 16'(g), 16'd64);
    check("blue high", 16'(b), 16'd64);
    bus_write(A_LED, 16'h0);
    bus_write(A_SDM_RED, 16'h0);
    bus_write(A_SDM_GREEN, 16'h0);
    bus_write(A_SDM_BLUE, 16'h0);
    count_pulses(64, r, g, b);
    check("red idle", 16'(r), 16'd0);
    check("green idle", 16'(g), 16'd0);
    check("blue idle", 16'(b), 16'd0);
  endtask

  task automatic tick_interrupt();
    int          edges;     // Rising edges since the write edge
    int          exp_edges;
    logic        seen;
    logic [15:0] v;
    exp_edges = 65536 - int'(TICK_LOAD);
    bus_write(A_TICKS, TICK_LOAD);
    edges = 0;
    seen  = 1'b0;
    while (!seen && edges < IRQ_LIMIT) begin
      @(negedge clk);
      edges++;
      if (irq) seen = 1'b1;
    end
    if (!seen) begin
      $display("timeout: irq never rose within %0d cycles of the tick write", IRQ_LIMIT);
      timeout_count++;
    end else begin
      check("irq rise edge", 16'(edges), 16'(exp_edges));
      @(negedge clk);
      edges++;
      check("irq width", 16'(irq), 16'h0);  // Single cycle
      bus_read(A_TICKS, v);
      edges++;
      check("ticks", v, TICK_LOAD + 16'(edges));  // Wrapped and counting
      bus_read(A_TICKS, v);
      edges++;
      check("ticks", v, TICK_LOAD + 16'(edges));
    end
  endtask

  task automatic cycle_counter();
    logic [15:0] c1;
    logic [15:0] c2;
    logic [15:0] n;
    for (int i = 0; i < 4; i++) begin
      rand_bits(6, n);
      n = n + 16'd1;  // 1 to 64 clocks apart
      bus_read(A_CYCLES, c1);
      repeat (n - 16'd1) @(negedge clk);
      bus_read(A_CYCLES, c2);  // Read itself adds one clock
      check("cycles delta", c2 - c1, n);
    end
  endtask

  initial begin
    arst_n        = 1'b0;
    bus           = '0;
    gpio_in       = '0;
    lfsr          = 16'd99;
    err_count     = 0;
    timeout_count = 0;
    check_count   = 0;
    repeat (2) @(posedge clk);  // Two cycles in reset
    @(negedge clk);
    arst_n = 1'b1;

    reset_values();
    bit_op_modes();
    port_inputs();
    sdm_density();
    tick_interrupt();
    cycle_counter();

    $display("checks: %0d, mismatches: %0d, timeouts: %0d",
             check_count, err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== build.f ====
io_types_pkg.sv
io_map_pkg.sv
bit_op_reg.sv
io_decode.sv
gpio_port.sv
led_sdm.sv
tick_timer.sv
io_top.sv
tb_io_top.sv

// ==== Makefile ====
# Verilator build and run for the I/O block testbench

VERILATOR ?= verilator
TOP       ?= tb_io_top
FLAGS     ?= --binary --timing
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f

BIN      := $(OBJ_DIR)/V$(TOP)
PASS_MSG := Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status follows the pass message in the output
run: compile
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
